// ==== hdl/exec_pkg.sv ====
// Shared types, operation codes, register map and structs; every execute unit file refers here
`default_nettype none

package exec_pkg;

  typedef logic [31:0] word_t;      // Operand and result word
  typedef logic [4:0]  alu_op_t;    // Operation code
  typedef logic [4:0]  reg_addr_t;  // Byte offset in register window

  // Operation codes
  localparam alu_op_t op_and    = 5'd0;
  localparam alu_op_t op_or     = 5'd1;
  localparam alu_op_t op_add    = 5'd2;
  localparam alu_op_t op_xor    = 5'd3;
  localparam alu_op_t op_sub    = 5'd4;
  localparam alu_op_t op_not    = 5'd5;
  localparam alu_op_t op_sll    = 5'd6;
  localparam alu_op_t op_srl    = 5'd7;
  localparam alu_op_t op_sra    = 5'd8;
  localparam alu_op_t op_slt    = 5'd9;
  localparam alu_op_t op_sltu   = 5'd10;
  localparam alu_op_t op_mul    = 5'd11;
  localparam alu_op_t op_mulh   = 5'd12;
  localparam alu_op_t op_mulhsu = 5'd13;
  localparam alu_op_t op_mulhu  = 5'd14;
  localparam alu_op_t op_div    = 5'd15;
  localparam alu_op_t op_divu   = 5'd16;
  localparam alu_op_t op_rem    = 5'd17;
  localparam alu_op_t op_remu   = 5'd18;
  localparam alu_op_t op_subu   = 5'd19;

  // Register window
  localparam reg_addr_t reg_operand_a = 5'h00;
  localparam reg_addr_t reg_operand_b = 5'h04;
  localparam reg_addr_t reg_control   = 5'h08;
  localparam reg_addr_t reg_status    = 5'h0C;
  localparam reg_addr_t reg_result    = 5'h10;

  // Status register bits
  localparam int stat_busy     = 0;
  localparam int stat_done     = 1;
  localparam int stat_zero     = 2;
  localparam int stat_negative = 3;
  localparam int stat_borrow   = 4;

  localparam int div_steps   = 32;  // One quotient bit per step
  localparam int mul_latency = 2;   // Start to valid

  // Request broadcast to every datapath unit
  typedef struct packed {
    alu_op_t op;
    word_t   a;
    word_t   b;
  } exec_req_t;

  // Result returned by a datapath unit
  typedef struct packed {
    word_t result;
    logic  borrow;
  } unit_resp_t;

  typedef logic [1:0] axil_resp_t;
  localparam axil_resp_t resp_okay   = 2'b00;
  localparam axil_resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire

// ==== hdl/alu.sv ====
// Combinational logic, add, subtract, shift and compare datapath; captured by the controller
`default_nettype none
`timescale 1ns/1ns

module alu (
  input  exec_pkg::exec_req_t  req,
  output exec_pkg::unit_resp_t res
);

  logic [4:0]  shamt;
  logic [32:0] diff_u;

  assign shamt  = req.b[4:0];                        // RV32 uses low five bits
  assign diff_u = {1'b0, req.a} - {1'b0, req.b};     // Bit 32 is the borrow out

  always_comb
  begin
    res = '0;
    case (req.op)
      exec_pkg::op_and:
        res.result = req.a & req.b;
      exec_pkg::op_or:
        res.result = req.a | req.b;
      exec_pkg::op_add:
        res.result = req.a + req.b;
      exec_pkg::op_xor:
        res.result = req.a ^ req.b;
      exec_pkg::op_sub:
        res.result = req.a - req.b;
      exec_pkg::op_not:
        res.result = ~req.a;
      exec_pkg::op_sll:
        res.result = req.a << shamt;
      exec_pkg::op_srl:
        res.result = req.a >> shamt;
      exec_pkg::op_sra:
        res.result = $signed(req.a) >>> shamt;      // Sign fill
      exec_pkg::op_slt:
        res.result = {31'b0, $signed(req.a) < $signed(req.b)};
      exec_pkg::op_sltu:
        res.result = {31'b0, req.a < req.b};
      exec_pkg::op_subu:
      begin
        res.result = diff_u[31:0];
        res.borrow = diff_u[32];                     // Set when a below b unsigned
      end
      default:
        res.result = '0;                             // Mul, div and illegal codes
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/mul_unit.sv ====
// Two-stage 33x33 signed multiplier covering mul, mulh, mulhsu and mulhu
`default_nettype none
`timescale 1ns/1ns

module mul_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mul_start,
  input  exec_pkg::exec_req_t  req,
  output logic                 mul_valid,
  output exec_pkg::unit_resp_t res
);

  logic                   a_signed;
  logic                   b_signed;
  logic signed [32:0]     a_s1;
  logic signed [32:0]     b_s1;
  exec_pkg::alu_op_t      op_s1;
  logic                   valid_s1;
  logic signed [65:0]     prod_s2;
  exec_pkg::alu_op_t      op_s2;
  logic                   valid_s2;

  // Only mulhu treats a as unsigned; mulhsu also keeps b unsigned
  assign a_signed = (req.op != exec_pkg::op_mulhu);
  assign b_signed = (req.op == exec_pkg::op_mul) || (req.op == exec_pkg::op_mulh);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end
    else
    begin
      valid_s1 <= mul_start;
      valid_s2 <= valid_s1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (mul_start)
    begin
      a_s1  <= {a_signed & req.a[31], req.a};  // Extend to 33 bits
      b_s1  <= {b_signed & req.b[31], req.b};
      op_s1 <= req.op;
    end
    if (valid_s1)
    begin
      prod_s2 <= a_s1 * b_s1;
      op_s2   <= op_s1;
    end
  end

  assign mul_valid  = valid_s2;
  assign res.result = (op_s2 == exec_pkg::op_mul) ? prod_s2[31:0] : prod_s2[63:32];
  assign res.borrow = 1'b0;

  assert property (@(posedge clk) disable iff (reset)
    mul_start |-> ##(exec_pkg::mul_latency) mul_valid);

endmodule

`default_nettype wire

// ==== hdl/div_unit.sv ====
// Iterative restoring divider for div, divu, rem and remu with RV32M corner cases
`default_nettype none
`timescale 1ns/1ns

module div_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 div_start,
  input  exec_pkg::exec_req_t  req,
  output logic                 div_valid,
  output exec_pkg::unit_resp_t res
);

  typedef enum logic [1:0] {div_idle, div_iter, div_fix} div_state_t;

  div_state_t       state;
  logic [5:0]       count;       // Quotient bits done
  exec_pkg::word_t  quo;
  exec_pkg::word_t  rem;
  exec_pkg::word_t  divisor;     // Magnitude of b
  exec_pkg::word_t  dividend;    // Original a
  logic             by_zero;
  logic             want_rem;
  logic             neg_q;
  logic             neg_r;
  logic             is_signed;
  exec_pkg::word_t  mag_a;
  exec_pkg::word_t  mag_b;
  logic [63:0]      first_step;
  logic [63:0]      next_step;
  exec_pkg::word_t  fix_q;
  exec_pkg::word_t  fix_r;
  exec_pkg::word_t  res_word;

  // One shift-and-subtract step returning {remainder, quotient}
  function automatic logic [63:0] div_step(input exec_pkg::word_t r,
                                           input exec_pkg::word_t q,
                                           input exec_pkg::word_t d);
    logic [32:0] shifted;
    logic [32:0] trial;
    shifted = {r, q[31]};
    trial   = shifted - {1'b0, d};
    if (trial[32])
      return {shifted[31:0], q[30:0], 1'b0};  // Restore
    else
      return {trial[31:0], q[30:0], 1'b1};
  endfunction

  assign is_signed  = (req.op == exec_pkg::op_div) || (req.op == exec_pkg::op_rem);
  assign mag_a      = (is_signed && req.a[31]) ? -req.a : req.a;
  assign mag_b      = (is_signed && req.b[31]) ? -req.b : req.b;
  assign first_step = div_step('0, mag_a, mag_b);  // First bit folded into the load
  assign next_step  = div_step(rem, quo, divisor);
  assign fix_q      = neg_q ? -quo : quo;
  assign fix_r      = neg_r ? -rem : rem;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= div_idle;
      count     <= '0;
      div_valid <= 1'b0;
    end
    else
    begin
      div_valid <= 1'b0;
      case (state)
        div_idle:
          if (div_start)
          begin
            state <= div_iter;
            count <= 6'd1;
          end
        div_iter:
        begin
          count <= count + 6'd1;
          if (count == 6'(exec_pkg::div_steps - 1))
            state <= div_fix;                  // Last bit lands this edge
        end
        default:
        begin
          state     <= div_idle;
          div_valid <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == div_idle && div_start)
    begin
      {rem, quo} <= first_step;
      divisor    <= mag_b;
      dividend   <= req.a;
      by_zero    <= (req.b == '0);
      want_rem   <= (req.op == exec_pkg::op_rem) || (req.op == exec_pkg::op_remu);
      neg_q      <= is_signed && (req.a[31] ^ req.b[31]);
      neg_r      <= is_signed && req.a[31];  // Remainder follows dividend
    end
    else if (state == div_iter)
      {rem, quo} <= next_step;
    // Signed overflow falls out since 0x80000000 negates to itself
    if (state == div_fix)
    begin
      if (by_zero)
        res_word <= want_rem ? dividend : '1;
      else
        res_word <= want_rem ? fix_r : fix_q;
    end
  end

  assign res = '{result: res_word, borrow: 1'b0};

  assert property (@(posedge clk) disable iff (reset) div_start |-> state == div_idle);

endmodule

`default_nettype wire

// ==== hdl/exec_ctrl.sv ====
// AXI4-Lite register block and sequencer that dispatches one operation and collects its result
`default_nettype none
`timescale 1ns/1ns

module exec_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 awvalid,
  output logic                 awready,
  input  exec_pkg::reg_addr_t  awaddr,
  input  logic                 wvalid,
  output logic                 wready,
  input  exec_pkg::word_t      wdata,
  input  logic [3:0]           wstrb,      // Partial strobes act as full writes
  output logic                 bvalid,
  input  logic                 bready,
  output exec_pkg::axil_resp_t bresp,
  input  logic                 arvalid,
  output logic                 arready,
  input  exec_pkg::reg_addr_t  araddr,
  output logic                 rvalid,
  input  logic                 rready,
  output exec_pkg::word_t      rdata,
  output exec_pkg::axil_resp_t rresp,
  output exec_pkg::exec_req_t  req,
  output logic                 mul_start,
  output logic                 div_start,
  input  logic                 mul_valid,
  input  logic                 div_valid,
  input  exec_pkg::unit_resp_t alu_res,
  input  exec_pkg::unit_resp_t mul_res,
  input  exec_pkg::unit_resp_t div_res
);

  typedef enum logic [1:0] {idle, run_alu, wait_mul, wait_div} ctrl_state_t;

  ctrl_state_t           state;
  exec_pkg::word_t       opnd_a;
  exec_pkg::word_t       opnd_b;
  exec_pkg::alu_op_t     ctrl_op;
  exec_pkg::word_t       result_q;
  logic                  busy;
  logic                  done;
  logic                  flag_zero;
  logic                  flag_neg;
  logic                  flag_borrow;
  logic                  wr_hs;
  logic                  rd_hs;
  exec_pkg::alu_op_t     wr_op;
  logic                  wr_is_mul;
  logic                  wr_is_div;
  logic                  ctrl_write;
  logic                  capture;
  exec_pkg::unit_resp_t  sel_res;
  exec_pkg::word_t       status_word;
  exec_pkg::word_t       rd_data;
  exec_pkg::axil_resp_t  rd_resp;
  exec_pkg::axil_resp_t  wr_resp;

  assign wr_hs      = awready && wready && awvalid && wvalid;
  assign rd_hs      = arready && arvalid;
  assign wr_op      = wdata[4:0];
  assign wr_is_mul  = (wr_op >= exec_pkg::op_mul) && (wr_op <= exec_pkg::op_mulhu);
  assign wr_is_div  = (wr_op >= exec_pkg::op_div) && (wr_op <= exec_pkg::op_remu);
  assign ctrl_write = wr_hs && (awaddr == exec_pkg::reg_control) && !busy;
  assign req        = '{op: ctrl_op, a: opnd_a, b: opnd_b};

  assign capture = (state == run_alu) || (state == wait_mul && mul_valid) ||
                   (state == wait_div && div_valid);

  always_comb
  begin
    case (state)
      wait_mul: sel_res = mul_res;
      wait_div: sel_res = div_res;
      default:  sel_res = alu_res;   // ALU settles in the start cycle
    endcase
  end

  always_comb
  begin
    status_word = '0;
    status_word[exec_pkg::stat_busy]     = busy;
    status_word[exec_pkg::stat_done]     = done;
    status_word[exec_pkg::stat_zero]     = flag_zero;
    status_word[exec_pkg::stat_negative] = flag_neg;
    status_word[exec_pkg::stat_borrow]   = flag_borrow;
  end

  always_comb
  begin
    wr_resp = exec_pkg::resp_okay;
    case (awaddr)
      exec_pkg::reg_operand_a, exec_pkg::reg_operand_b,
      exec_pkg::reg_status, exec_pkg::reg_result: wr_resp = exec_pkg::resp_okay;
      exec_pkg::reg_control: if (busy) wr_resp = exec_pkg::resp_slverr;  // Write dropped
      default: wr_resp = exec_pkg::resp_slverr;
    endcase
  end

  always_comb
  begin
    rd_data = '0;
    rd_resp = exec_pkg::resp_okay;
    case (araddr)
      exec_pkg::reg_operand_a: rd_data = opnd_a;
      exec_pkg::reg_operand_b: rd_data = opnd_b;
      exec_pkg::reg_control:   rd_data = {27'b0, ctrl_op};
      exec_pkg::reg_status:    rd_data = status_word;
      exec_pkg::reg_result:    rd_data = result_q;
      default:                 rd_resp = exec_pkg::resp_slverr;
    endcase
  end

  // AW and W accepted together on the write channel
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end
    else
    begin
      awready <= !awready && awvalid && wvalid && !bvalid;  // One-cycle pulse
      wready  <= !awready && awvalid && wvalid && !bvalid;
      if (wr_hs)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  // Read channel
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end
    else if (rd_hs)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b1;
    end
    else if (rvalid)
    begin
      if (rready)
      begin
        rvalid  <= 1'b0;
        arready <= 1'b1;
      end
    end
    else
      arready <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (wr_hs)
      bresp <= wr_resp;
    if (rd_hs)
    begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      opnd_a <= '0;
      opnd_b <= '0;
    end
    else if (wr_hs)
    begin
      if (awaddr == exec_pkg::reg_operand_a)
        opnd_a <= wdata;
      if (awaddr == exec_pkg::reg_operand_b)
        opnd_b <= wdata;
    end
  end

  // Sequencer
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= idle;
      ctrl_op     <= '0;
      result_q    <= '0;
      busy        <= 1'b0;
      done        <= 1'b0;
      flag_zero   <= 1'b0;
      flag_neg    <= 1'b0;
      flag_borrow <= 1'b0;
      mul_start   <= 1'b0;
      div_start   <= 1'b0;
    end
    else
    begin
      mul_start <= 1'b0;
      div_start <= 1'b0;
      if (ctrl_write)
      begin
        ctrl_op <= wr_op;
        busy    <= 1'b1;
        done    <= 1'b0;
        if (wr_is_mul)
        begin
          state     <= wait_mul;
          mul_start <= 1'b1;
        end
        else if (wr_is_div)
        begin
          state     <= wait_div;
          div_start <= 1'b1;
        end
        else
          state <= run_alu;           // Includes illegal codes
      end
      else if (capture)
      begin
        result_q    <= sel_res.result;
        flag_zero   <= (sel_res.result == '0);
        flag_neg    <= sel_res.result[31];
        flag_borrow <= sel_res.borrow;
        busy        <= 1'b0;
        done        <= 1'b1;
        state       <= idle;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid);
  assert property (@(posedge clk) disable iff (reset) !(mul_start && div_start));

endmodule

`default_nettype wire

// ==== hdl/exec_unit_top.sv ====
// Top level of the execute unit; AXI4-Lite slave wired to the ALU, multiplier and divider
`default_nettype none
`timescale 1ns/1ns

module exec_unit_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 awvalid,
  output logic                 awready,
  input  exec_pkg::reg_addr_t  awaddr,
  input  logic                 wvalid,
  output logic                 wready,
  input  exec_pkg::word_t      wdata,
  input  logic [3:0]           wstrb,
  output logic                 bvalid,
  input  logic                 bready,
  output exec_pkg::axil_resp_t bresp,
  input  logic                 arvalid,
  output logic                 arready,
  input  exec_pkg::reg_addr_t  araddr,
  output logic                 rvalid,
  input  logic                 rready,
  output exec_pkg::word_t      rdata,
  output exec_pkg::axil_resp_t rresp
);

  exec_pkg::exec_req_t  req;        // Shared by all three units
  exec_pkg::unit_resp_t alu_res;
  exec_pkg::unit_resp_t mul_res;
  exec_pkg::unit_resp_t div_res;
  logic                 mul_start;
  logic                 div_start;
  logic                 mul_valid;
  logic                 div_valid;

  exec_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .req       (req),
    .mul_start (mul_start),
    .div_start (div_start),
    .mul_valid (mul_valid),
    .div_valid (div_valid),
    .alu_res   (alu_res),
    .mul_res   (mul_res),
    .div_res   (div_res)
  );

  alu u_alu (
    .req (req),
    .res (alu_res)
  );

  mul_unit u_mul (
    .clk       (clk),
    .reset     (reset),
    .mul_start (mul_start),
    .req       (req),
    .mul_valid (mul_valid),
    .res       (mul_res)
  );

  div_unit u_div (
    .clk       (clk),
    .reset     (reset),
    .div_start (div_start),
    .req       (req),
    .div_valid (div_valid),
    .res       (div_res)
  );

endmodule

`default_nettype wire

// ==== tests/exec_unit_tb.sv ====
// Testbench for the execute unit; drives AXI4-Lite host transfers from a table and checks results
`default_nettype none
`timescale 1ns/1ns

module exec_unit_tb;

  typedef struct packed {
    exec_pkg::alu_op_t op;
    exec_pkg::word_t   a;
    exec_pkg::word_t   b;
    exec_pkg::word_t   exp_res;
    logic [4:0]        exp_flags;  // Borrow, negative, zero, done, busy
  } test_row_t;

  logic                   clk;
  logic                   reset;
  logic                   awvalid;
  logic                   awready;
  exec_pkg::reg_addr_t    awaddr;
  logic                   wvalid;
  logic                   wready;
  exec_pkg::word_t        wdata;
  logic [3:0]             wstrb;
  logic                   bvalid;
  logic                   bready;
  exec_pkg::axil_resp_t   bresp;
  logic                   arvalid;
  logic                   arready;
  exec_pkg::reg_addr_t    araddr;
  logic                   rvalid;
  logic                   rready;
  exec_pkg::word_t        rdata;
  exec_pkg::axil_resp_t   rresp;

  test_row_t rows[$];
  logic      table_ready;
  int        error_count;
  int        errors_at_start;
  int        test_count;
  int        failed_count;
  string     test_name;

  exec_unit_top uut (
    .clk     (clk),
    .reset   (reset),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // Expected {borrow, result} from the RV32IM rules
  function automatic logic [32:0] model_op(input exec_pkg::alu_op_t op,
                                           input exec_pkg::word_t a,
                                           input exec_pkg::word_t b);
    longint          sa;
    longint          sb;
    longint          ua;
    longint          ub;
    logic [63:0]     prod;
    exec_pkg::word_t r;
    logic            brw;
    logic            ovf;
    sa   = $signed(a);
    sb   = $signed(b);
    ua   = {32'b0, a};
    ub   = {32'b0, b};
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    r    = '0;
    brw  = 1'b0;
    prod = '0;
    case (op)
      exec_pkg::op_and:    r = a & b;
      exec_pkg::op_or:     r = a | b;
      exec_pkg::op_add:    r = a + b;
      exec_pkg::op_xor:    r = a ^ b;
      exec_pkg::op_sub:    r = a - b;
      exec_pkg::op_not:    r = ~a;
      exec_pkg::op_sll:    r = a << b[4:0];
      exec_pkg::op_srl:    r = a >> b[4:0];
      exec_pkg::op_sra:
      begin
        prod = sa >> b[4:0];  // Sign bits come down from the upper word
        r    = prod[31:0];
      end
      exec_pkg::op_slt:    r = (sa < sb) ? 32'd1 : 32'd0;
      exec_pkg::op_sltu:   r = (ua < ub) ? 32'd1 : 32'd0;
      exec_pkg::op_mul,
      exec_pkg::op_mulh:
      begin
        prod = sa * sb;
        r    = (op == exec_pkg::op_mul) ? prod[31:0] : prod[63:32];
      end
      exec_pkg::op_mulhsu:
      begin
        prod = sa * ub;
        r    = prod[63:32];
      end
      exec_pkg::op_mulhu:
      begin
        prod = ua * ub;
        r    = prod[63:32];
      end
      exec_pkg::op_div:
      begin
        prod = sa / ((b == '0 || ovf) ? 64'sd1 : sb);
        r    = (b == '0) ? 32'hffff_ffff : (ovf ? a : prod[31:0]);
      end
      exec_pkg::op_divu:
      begin
        prod = ua / ((b == '0) ? 64'sd1 : ub);
        r    = (b == '0) ? 32'hffff_ffff : prod[31:0];
      end
      exec_pkg::op_rem:
      begin
        prod = sa % ((b == '0 || ovf) ? 64'sd1 : sb);  // Sign follows the dividend
        r    = (b == '0) ? a : (ovf ? 32'd0 : prod[31:0]);
      end
      exec_pkg::op_remu:
      begin
        prod = ua % ((b == '0) ? 64'sd1 : ub);
        r    = (b == '0) ? a : prod[31:0];
      end
      exec_pkg::op_subu:
      begin
        r   = a - b;
        brw = (ua < ub);
      end
      default:             r = '0;  // Codes 20 to 31
    endcase
    return {brw, r};
  endfunction

  task automatic add_row(input exec_pkg::alu_op_t op, input exec_pkg::word_t a,
                         input exec_pkg::word_t b);
    test_row_t   row;
    logic [32:0] m;
    m             = model_op(op, a, b);
    row.op        = op;
    row.a         = a;
    row.b         = b;
    row.exp_res   = m[31:0];
    row.exp_flags = {m[32], m[31], m[31:0] == 32'd0, 1'b1, 1'b0};
    rows.push_back(row);
  endtask

  task automatic build_table();
    add_row(exec_pkg::op_and,    32'hffff_0000, 32'h0f0f_0f0f);
    add_row(exec_pkg::op_or,     32'h0000_0000, 32'h0000_0000);
    add_row(exec_pkg::op_add,    32'hffff_ffff, 32'h0000_0001);
    add_row(exec_pkg::op_add,    32'h7fff_ffff, 32'h0000_0001);
    add_row(exec_pkg::op_xor,    32'ha5a5_a5a5, 32'h5a5a_5a5a);
    add_row(exec_pkg::op_sub,    32'h0000_0005, 32'h0000_0007);
    add_row(exec_pkg::op_not,    32'hffff_ffff, 32'h0000_0000);
    add_row(exec_pkg::op_sll,    32'h0000_0001, 32'h0000_001f);
    add_row(exec_pkg::op_sll,    32'h0000_0001, 32'h0000_003f);  // Upper shift bits ignored
    add_row(exec_pkg::op_srl,    32'h8000_0000, 32'h0000_001f);
    add_row(exec_pkg::op_sra,    32'h8000_0000, 32'h0000_001f);
    add_row(exec_pkg::op_slt,    32'hffff_ffff, 32'h0000_0001);
    add_row(exec_pkg::op_sltu,   32'hffff_ffff, 32'h0000_0001);
    add_row(exec_pkg::op_subu,   32'h0000_0003, 32'h0000_0005);
    add_row(exec_pkg::op_subu,   32'h0000_0005, 32'h0000_0003);
    add_row(exec_pkg::op_subu,   32'h0000_0007, 32'h0000_0007);
    add_row(exec_pkg::op_mul,    32'hffff_ffff, 32'h0000_0007);
    add_row(exec_pkg::op_mul,    32'h8000_0000, 32'hffff_ffff);
    add_row(exec_pkg::op_mulh,   32'h8000_0000, 32'h8000_0000);
    add_row(exec_pkg::op_mulh,   32'hffff_ffff, 32'h0000_0007);
    add_row(exec_pkg::op_mulhsu, 32'hffff_ffff, 32'hffff_ffff);
    add_row(exec_pkg::op_mulhsu, 32'h8000_0000, 32'h0000_0002);
    add_row(exec_pkg::op_mulhu,  32'hffff_ffff, 32'hffff_ffff);
    add_row(exec_pkg::op_mulhu,  32'h8000_0000, 32'h0000_0003);
    add_row(exec_pkg::op_div,    32'hffff_fff9, 32'h0000_0002);
    add_row(exec_pkg::op_div,    32'h8000_0000, 32'hffff_ffff);  // Signed overflow
    add_row(exec_pkg::op_div,    32'h0000_0005, 32'h0000_0000);
    add_row(exec_pkg::op_divu,   32'hffff_ffff, 32'h0000_0010);
    add_row(exec_pkg::op_divu,   32'h0000_0005, 32'h0000_0000);
    add_row(exec_pkg::op_rem,    32'hffff_fff9, 32'h0000_0002);
    add_row(exec_pkg::op_rem,    32'h8000_0000, 32'hffff_ffff);
    add_row(exec_pkg::op_rem,    32'h0000_0005, 32'h0000_0000);
    add_row(exec_pkg::op_remu,   32'hffff_ffff, 32'h0000_0010);
    add_row(exec_pkg::op_remu,   32'h0000_0009, 32'h0000_0000);
    for (int code = 20; code < 32; code++)
      add_row(exec_pkg::alu_op_t'(code), 32'h0000_1234, 32'h0000_5678);
    for (int n = 0; n < 20; n++)
      add_row(exec_pkg::alu_op_t'($urandom_range(0, 19)), $urandom, $urandom);
  endtask

  task automatic check_value(input string name, input exec_pkg::word_t got,
                             input exec_pkg::word_t exp);
    assert (got === exp)
    else
    begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test();
    test_count++;
    if (error_count == errors_at_start)
      $display("test %0d %s: ok", test_count, test_name);
    else
    begin
      failed_count++;
      $display("test %0d %s: failed", test_count, test_name);
    end
  endtask

  // AW and W offered together and B taken as soon as it shows
  task automatic write_reg(input exec_pkg::reg_addr_t addr, input exec_pkg::word_t data,
                           output exec_pkg::axil_resp_t resp);
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hf;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    @(negedge clk);
    while (!(awready && wready))
      @(negedge clk);
    @(posedge clk);         // Handshake edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    @(negedge clk);
    while (!bvalid)
      @(negedge clk);
    resp = bresp;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic read_reg(input exec_pkg::reg_addr_t addr, output exec_pkg::word_t data,
                          output exec_pkg::axil_resp_t resp);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready)
      @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    @(negedge clk);
    while (!rvalid)
      @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic poll_done(output exec_pkg::word_t status);
    exec_pkg::axil_resp_t resp;
    status = '0;
    while (!status[exec_pkg::stat_done])
      read_reg(exec_pkg::reg_status, status, resp);
  endtask

  task automatic run_row(input int idx, input test_row_t row);
    exec_pkg::word_t      data;
    exec_pkg::word_t      status;
    exec_pkg::axil_resp_t resp;
    start_test($sformatf("row %0d op %0d", idx, row.op));
    write_reg(exec_pkg::reg_operand_a, row.a, resp);
    check_value("bresp", {30'b0, resp}, {30'b0, exec_pkg::resp_okay});
    write_reg(exec_pkg::reg_operand_b, row.b, resp);
    check_value("bresp", {30'b0, resp}, {30'b0, exec_pkg::resp_okay});
    write_reg(exec_pkg::reg_control, {27'b0, row.op}, resp);
    check_value("bresp", {30'b0, resp}, {30'b0, exec_pkg::resp_okay});
    poll_done(status);
    read_reg(exec_pkg::reg_status, status, resp);
    check_value("status", status, {27'b0, row.exp_flags});
    read_reg(exec_pkg::reg_result, data, resp);
    check_value("result", data, row.exp_res);
    end_test();
  endtask

  // Watchdog sized from the table length
  initial
  begin
    longint timeout_ns;
    wait (table_ready);
    timeout_ns = longint'(rows.size() + 10) * 60 * 40 + 16 * 40 + 20000;
    #(timeout_ns);
    $display("Run timed out after %0d ns with tests still running", timeout_ns);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    exec_pkg::word_t      data;
    exec_pkg::word_t      status;
    exec_pkg::axil_resp_t resp;
    reset           = 1'b1;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    wstrb           = 4'h0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    error_count     = 0;
    errors_at_start = 0;
    test_count      = 0;
    failed_count    = 0;
    table_ready     = 1'b0;
    void'($urandom(32'hd2420aa0));
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    start_test("status after reset");
    read_reg(exec_pkg::reg_status, data, resp);
    check_value("status", data, 32'd0);
    check_value("rresp", {30'b0, resp}, {30'b0, exec_pkg::resp_okay});
    end_test();

    start_test("operand readback");
    write_reg(exec_pkg::reg_operand_a, 32'h1234_5678, resp);
    read_reg(exec_pkg::reg_operand_a, data, resp);
    check_value("operand_a", data, 32'h1234_5678);
    write_reg(exec_pkg::reg_operand_b, 32'h9abc_def0, resp);
    read_reg(exec_pkg::reg_operand_b, data, resp);
    check_value("operand_b", data, 32'h9abc_def0);
    end_test();

    foreach (rows[i])
      run_row(i, rows[i]);

    start_test("control write while busy");
    write_reg(exec_pkg::reg_operand_a, 32'd100, resp);
    write_reg(exec_pkg::reg_operand_b, 32'd7, resp);
    write_reg(exec_pkg::reg_control, {27'b0, exec_pkg::op_div}, resp);
    write_reg(exec_pkg::reg_control, {27'b0, exec_pkg::op_add}, resp);  // Lands mid divide
    check_value("bresp", {30'b0, resp}, {30'b0, exec_pkg::resp_slverr});
    poll_done(status);
    read_reg(exec_pkg::reg_result, data, resp);
    check_value("result", data, 32'd14);
    read_reg(exec_pkg::reg_control, data, resp);
    check_value("control", data, {27'b0, exec_pkg::op_div});
    end_test();

    start_test("unmapped address");
    read_reg(5'h14, data, resp);
    check_value("rresp", {30'b0, resp}, {30'b0, exec_pkg::resp_slverr});
    check_value("rdata", data, 32'd0);
    write_reg(5'h18, 32'hdead_beef, resp);
    check_value("bresp", {30'b0, resp}, {30'b0, exec_pkg::resp_slverr});
    end_test();

    $display("Tests run %0d, tests failed %0d, check errors %0d",
             test_count, failed_count, error_count);
    if (error_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/exec_pkg.sv
hdl/alu.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/exec_ctrl.sv
hdl/exec_unit_top.sv
tests/exec_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the execute unit testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module exec_unit_tb \
  -o exec_unit_sim \
  && ./obj_dir/exec_unit_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log

grep -qx ">>> PASS" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
